/* rtl/lsu_pkg.sv */
// -------------------------------------------------------------------------
// Load/store pipeline shared definitions
// Widths, depths, RISC-V opcode and size encodings, exception codes,
// the result record and the byte lane helpers
// -------------------------------------------------------------------------
`default_nettype none

package lsu_pkg;

  localparam int XLEN_W      = 64;
  localparam int DATA_B      = 8;
  localparam int BYTE_OFS_W  = 3;
  localparam int INST_W      = 32;
  localparam int TAG_W       = 8;

  localparam int DMEM_DEPTH  = 64;
  localparam int DMEM_ADDR_W = 6;

  localparam int RESQ_DEPTH  = 4;
  localparam int RESQ_PTR_W  = 2;
  localparam int RESQ_CNT_W  = 3;

  // Major opcodes handled here
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3[1:0] order
  typedef enum logic [1:0] {SIZE_B, SIZE_H, SIZE_W, SIZE_DW} size_t;

  typedef enum logic [1:0] {OP_NONE, OP_LOAD, OP_STORE} mem_op_t;

  // mcause values
  typedef enum logic [3:0] {
    EXC_NONE           = 4'd0,
    EXC_ILLEGAL        = 4'd2,
    EXC_LOAD_MISALIGN  = 4'd4,
    EXC_STORE_MISALIGN = 4'd6
  } except_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [XLEN_W-1:0] data;
    logic              except_valid;
    except_t           except_type;
    logic [XLEN_W-1:0] tval;
  } lsu_result_t;

  // Bytes touched by an access within its doubleword
  function automatic logic [DATA_B-1:0] byte_mask(size_t size, logic [BYTE_OFS_W-1:0] ofs);
    logic [DATA_B-1:0] base;
    case (size)
      SIZE_B:  base = 8'h01;
      SIZE_H:  base = 8'h03;
      SIZE_W:  base = 8'h0f;
      default: base = 8'hff;
    endcase
    return base << ofs;
  endfunction

  // Moves store data from the low lanes into its byte position
  function automatic logic [XLEN_W-1:0] place_data(logic [XLEN_W-1:0] data,
                                                   logic [BYTE_OFS_W-1:0] ofs);
    return data << {ofs, 3'b000};
  endfunction

endpackage

`default_nettype wire

/* rtl/lsu_stage_if.sv */
// -------------------------------------------------------------------------
// EX2 stage bundle from address generation to the aligner and data RAM
// -------------------------------------------------------------------------
`default_nettype none

interface lsu_stage_if import lsu_pkg::*; ();

  logic              valid;
  logic [TAG_W-1:0]  tag;
  mem_op_t           op;
  size_t             size;
  logic              sign;
  logic [XLEN_W-1:0] addr;
  logic [XLEN_W-1:0] st_data;
  logic              except_valid;
  except_t           except_type;
  logic [INST_W-1:0] inst;

  modport source (output valid, tag, op, size, sign, addr, st_data, except_valid,
                  except_type, inst);
  modport sink   (input valid, tag, op, size, sign, addr, st_data, except_valid,
                  except_type, inst);
  // Store write port only needs the address side
  modport store  (input valid, op, addr, size, st_data, except_valid);

endinterface

`default_nettype wire

/* rtl/lsu_agen.sv */
// -------------------------------------------------------------------------
// EX0/EX1 of the load/store pipeline
// Issue register, load/store decode, address generation, alignment and
// illegal checks, data RAM read request and the EX2 register
// -------------------------------------------------------------------------
`default_nettype none

module lsu_agen
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_issue_valid,
  input  logic [TAG_W-1:0]       i_issue_tag,
  input  logic [INST_W-1:0]      i_issue_inst,
  input  logic [XLEN_W-1:0]      i_issue_rs1,
  input  logic [XLEN_W-1:0]      i_issue_rs2,
  lsu_stage_if.source            o_ex2,
  output logic                   o_rd_en,
  output logic [DMEM_ADDR_W-1:0] o_rd_idx
);

  logic              r_ex1_valid;
  logic [TAG_W-1:0]  r_ex1_tag;
  logic [INST_W-1:0] r_ex1_inst;
  logic [XLEN_W-1:0] r_ex1_rs1;
  logic [XLEN_W-1:0] r_ex1_rs2;

  mem_op_t           w_op;
  size_t             w_size;
  logic              w_sign;
  logic              w_illegal;
  logic              w_misalign;
  logic [XLEN_W-1:0] w_offset;
  logic [XLEN_W-1:0] w_addr;
  except_t           w_except_type;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_tag  <= i_issue_tag;
    r_ex1_inst <= i_issue_inst;
    r_ex1_rs1  <= i_issue_rs1;
    r_ex1_rs2  <= i_issue_rs2;
  end

  // -------------------------------------------------------------------------
  // EX1 decode and address
  // -------------------------------------------------------------------------
  always_comb begin
    w_size = size_t'(r_ex1_inst[13:12]);
    // funct3[2] selects the unsigned loads
    w_sign = ~r_ex1_inst[14];
    case (r_ex1_inst[6:0])
      OPC_LOAD: begin
        w_op      = OP_LOAD;
        w_offset  = {{(XLEN_W-12){r_ex1_inst[31]}}, r_ex1_inst[31:20]};
        w_illegal = (r_ex1_inst[14:12] == 3'b111);
      end
      OPC_STORE: begin
        w_op      = OP_STORE;
        w_offset  = {{(XLEN_W-12){r_ex1_inst[31]}}, r_ex1_inst[31:25], r_ex1_inst[11:7]};
        w_illegal = r_ex1_inst[14];
      end
      default: begin
        w_op      = OP_NONE;
        w_offset  = '0;
        w_illegal = 1'b1;
      end
    endcase

    w_addr = r_ex1_rs1 + w_offset;

    case (w_size)
      SIZE_H:  w_misalign = w_addr[0];
      SIZE_W:  w_misalign = |w_addr[1:0];
      SIZE_DW: w_misalign = |w_addr[2:0];
      default: w_misalign = 1'b0;
    endcase

    if (w_illegal) begin
      w_except_type = EXC_ILLEGAL;
    end else if (w_misalign) begin
      w_except_type = (w_op == OP_STORE) ? EXC_STORE_MISALIGN : EXC_LOAD_MISALIGN;
    end else begin
      w_except_type = EXC_NONE;
    end
  end

  // Read the whole doubleword, the aligner picks the lanes
  assign o_rd_en  = r_ex1_valid & (w_op == OP_LOAD) & (w_except_type == EXC_NONE);
  assign o_rd_idx = w_addr[BYTE_OFS_W +: DMEM_ADDR_W];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ex2.valid <= 1'b0;
    end else begin
      o_ex2.valid <= r_ex1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex2.tag          <= r_ex1_tag;
    o_ex2.op           <= w_op;
    o_ex2.size         <= w_size;
    o_ex2.sign         <= w_sign;
    o_ex2.addr         <= w_addr;
    o_ex2.st_data      <= r_ex1_rs2;
    o_ex2.except_valid <= (w_except_type != EXC_NONE);
    o_ex2.except_type  <= w_except_type;
    o_ex2.inst         <= r_ex1_inst;
  end

endmodule

`default_nettype wire

/* rtl/lsu_data_ram.sv */
// -------------------------------------------------------------------------
// Local data RAM with byte enables
// Store write port fed from EX2, registered read port for EX1 loads
// -------------------------------------------------------------------------
`default_nettype none

module lsu_data_ram
  import lsu_pkg::*;
(
  input  logic                   i_clk,
  lsu_stage_if.store             i_st,
  input  logic                   i_rd_en,
  input  logic [DMEM_ADDR_W-1:0] i_rd_idx,
  output logic [XLEN_W-1:0]      o_rd_data
);

  logic [XLEN_W-1:0]      r_mem [DMEM_DEPTH];
  logic                   w_wr_en;
  logic [DMEM_ADDR_W-1:0] w_wr_idx;
  logic [DATA_B-1:0]      w_wr_be;
  logic [XLEN_W-1:0]      w_wr_data;

  assign w_wr_en   = i_st.valid & (i_st.op == OP_STORE) & ~i_st.except_valid;
  assign w_wr_idx  = i_st.addr[BYTE_OFS_W +: DMEM_ADDR_W];
  assign w_wr_be   = byte_mask(i_st.size, i_st.addr[BYTE_OFS_W-1:0]);
  assign w_wr_data = place_data(i_st.st_data, i_st.addr[BYTE_OFS_W-1:0]);

  // Same-edge read sees the old word
  always_ff @(posedge i_clk) begin
    for (int b = 0; b < DATA_B; b++) begin
      if (w_wr_en && w_wr_be[b]) begin
        r_mem[w_wr_idx][b*8 +: 8] <= w_wr_data[b*8 +: 8];
      end
    end
    if (i_rd_en) begin
      o_rd_data <= r_mem[i_rd_idx];
    end
  end

endmodule

`default_nettype wire

/* rtl/lsu_load_align.sv */
// -------------------------------------------------------------------------
// EX2/EX3 of the load/store pipeline
// Store-to-load byte forwarding from EX3, lane extraction, size and sign
// extension, trap value select and the EX3 result register
// -------------------------------------------------------------------------
`default_nettype none

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  lsu_stage_if.sink         i_ex2,
  input  logic [XLEN_W-1:0] i_rd_data,
  output logic              o_ex3_valid,
  output lsu_result_t       o_ex3_result
);

  logic [DATA_B-1:0]      w_ex2_mask;
  logic                   w_is_load;
  logic                   w_idx_match;
  logic [DATA_B-1:0]      w_fwd_sel;
  logic [XLEN_W-1:0]      w_merged;
  logic [XLEN_W-1:0]      w_shifted;
  logic [XLEN_W-1:0]      w_ext;

  // Store sitting in EX3, already written to RAM this edge
  logic                   r_st_valid;
  logic [DMEM_ADDR_W-1:0] r_st_idx;
  logic [DATA_B-1:0]      r_st_mask;
  logic [XLEN_W-1:0]      r_st_data;

  logic                   r_ex3_valid;
  lsu_result_t            r_ex3_result;

  // Expected bytes for a load, write enables for a store
  assign w_ex2_mask  = byte_mask(i_ex2.size, i_ex2.addr[BYTE_OFS_W-1:0]);
  assign w_is_load   = (i_ex2.op == OP_LOAD) & ~i_ex2.except_valid;
  assign w_idx_match = r_st_valid & (r_st_idx == i_ex2.addr[BYTE_OFS_W +: DMEM_ADDR_W]);

  always_comb begin
    for (int b = 0; b < DATA_B; b++) begin
      w_fwd_sel[b]       = w_idx_match & w_ex2_mask[b] & r_st_mask[b];
      w_merged[b*8 +: 8] = w_fwd_sel[b] ? r_st_data[b*8 +: 8] : i_rd_data[b*8 +: 8];
    end
    w_shifted = w_merged >> {i_ex2.addr[BYTE_OFS_W-1:0], 3'b000};
    case (i_ex2.size)
      SIZE_B:  w_ext = {{(XLEN_W-8){i_ex2.sign & w_shifted[7]}}, w_shifted[7:0]};
      SIZE_H:  w_ext = {{(XLEN_W-16){i_ex2.sign & w_shifted[15]}}, w_shifted[15:0]};
      SIZE_W:  w_ext = {{(XLEN_W-32){i_ex2.sign & w_shifted[31]}}, w_shifted[31:0]};
      default: w_ext = w_shifted;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_st_valid  <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_st_valid  <= i_ex2.valid & (i_ex2.op == OP_STORE) & ~i_ex2.except_valid;
      r_ex3_valid <= i_ex2.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_st_idx                  <= i_ex2.addr[BYTE_OFS_W +: DMEM_ADDR_W];
    r_st_mask                 <= w_ex2_mask;
    r_st_data                 <= place_data(i_ex2.st_data, i_ex2.addr[BYTE_OFS_W-1:0]);

    r_ex3_result.tag          <= i_ex2.tag;
    r_ex3_result.data         <= w_is_load ? w_ext : '0;
    r_ex3_result.except_valid <= i_ex2.except_valid;
    r_ex3_result.except_type  <= i_ex2.except_type;
    r_ex3_result.tval         <= (i_ex2.except_type == EXC_ILLEGAL) ? XLEN_W'(i_ex2.inst) :
                                                                      i_ex2.addr;
  end

  assign o_ex3_valid  = r_ex3_valid;
  assign o_ex3_result = r_ex3_result;

endmodule

`default_nettype wire

/* rtl/lsu_result_queue.sv */
// -------------------------------------------------------------------------
// In-order result FIFO behind EX3
// Accepted pops hand one issue credit back
// -------------------------------------------------------------------------
`default_nettype none

module lsu_result_queue
  import lsu_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset_n,
  input  logic        i_push,
  input  lsu_result_t i_push_data,
  input  logic        i_pop,
  output logic        o_valid,
  output lsu_result_t o_head,
  output logic        o_credit
);

  lsu_result_t           r_mem [RESQ_DEPTH];
  logic [RESQ_PTR_W-1:0] r_wr_ptr;
  logic [RESQ_PTR_W-1:0] r_rd_ptr;
  logic [RESQ_CNT_W-1:0] r_count;
  logic                  w_pop_ok;

  assign o_valid  = (r_count != '0);
  assign w_pop_ok = i_pop & o_valid;
  assign o_credit = w_pop_ok;
  assign o_head   = r_mem[r_rd_ptr];

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop_ok) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      r_count <= r_count + RESQ_CNT_W'(i_push) - RESQ_CNT_W'(w_pop_ok);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_mem[r_wr_ptr] <= i_push_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/lsu_pipe_top.sv */
// -------------------------------------------------------------------------
// Load/store pipeline top level
// Address generation, data RAM, aligner and result queue
// -------------------------------------------------------------------------
`default_nettype none

module lsu_pipe_top
  import lsu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,

  // Issue side
  input  logic              i_issue_valid,
  input  logic [TAG_W-1:0]  i_issue_tag,
  input  logic [INST_W-1:0] i_issue_inst,
  input  logic [XLEN_W-1:0] i_issue_rs1,
  input  logic [XLEN_W-1:0] i_issue_rs2,
  output logic              o_issue_credit,

  // Result side
  output logic              o_res_valid,
  output logic [TAG_W-1:0]  o_res_tag,
  output logic [XLEN_W-1:0] o_res_data,
  output logic              o_res_except_valid,
  output except_t           o_res_except_type,
  output logic [XLEN_W-1:0] o_res_tval,
  input  logic              i_res_pop
);

  lsu_stage_if u_ex2_if ();

  logic                   w_rd_en;
  logic [DMEM_ADDR_W-1:0] w_rd_idx;
  logic [XLEN_W-1:0]      w_rd_data;
  logic                   w_ex3_valid;
  lsu_result_t            w_ex3_result;
  lsu_result_t            w_head;

  lsu_agen u_agen (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (i_issue_valid),
    .i_issue_tag   (i_issue_tag),
    .i_issue_inst  (i_issue_inst),
    .i_issue_rs1   (i_issue_rs1),
    .i_issue_rs2   (i_issue_rs2),
    .o_ex2         (u_ex2_if.source),
    .o_rd_en       (w_rd_en),
    .o_rd_idx      (w_rd_idx)
  );

  lsu_data_ram u_data_ram (
    .i_clk     (i_clk),
    .i_st      (u_ex2_if.store),
    .i_rd_en   (w_rd_en),
    .i_rd_idx  (w_rd_idx),
    .o_rd_data (w_rd_data)
  );

  lsu_load_align u_load_align (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_ex2        (u_ex2_if.sink),
    .i_rd_data    (w_rd_data),
    .o_ex3_valid  (w_ex3_valid),
    .o_ex3_result (w_ex3_result)
  );

  lsu_result_queue u_result_queue (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_push      (w_ex3_valid),
    .i_push_data (w_ex3_result),
    .i_pop       (i_res_pop),
    .o_valid     (o_res_valid),
    .o_head      (w_head),
    .o_credit    (o_issue_credit)
  );

  assign o_res_tag          = w_head.tag;
  assign o_res_data         = w_head.data;
  assign o_res_except_valid = w_head.except_valid;
  assign o_res_except_type  = w_head.except_type;
  assign o_res_tval         = w_head.tval;

endmodule

`default_nettype wire

/* tests/lsu_pipe_props.sv */
// -------------------------------------------------------------------------
// Bound checks on the pipeline top level
// Credit accounting, reset state and single-issue latency
// -------------------------------------------------------------------------
`default_nettype none

module lsu_pipe_props import lsu_pkg::*; (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_issue_valid,
  input logic i_res_pop,
  input logic o_res_valid,
  input logic o_issue_credit
);

  timeunit 1ns;
  timeprecision 100ps;

  // Issued and not yet popped
  logic [3:0] r_outstanding;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_outstanding <= '0;
    end else begin
      r_outstanding <= r_outstanding + 4'(i_issue_valid) - 4'(i_res_pop & o_res_valid);
    end
  end

  assert property (@(posedge i_clk) disable iff (!i_reset_n)
                   r_outstanding <= 4'(RESQ_DEPTH))
    else $error("More instructions outstanding than result queue entries");

  assert property (@(posedge i_clk) !i_reset_n |-> !o_res_valid && !o_issue_credit)
    else $error("Result valid or credit high during reset");

  assert property (@(posedge i_clk) $rose(i_reset_n) |-> !o_res_valid && !o_issue_credit)
    else $error("Result valid or credit high right after reset");

  // Result visible in the cycle after edge E+3 of an empty pipe
  assert property (@(posedge i_clk) disable iff (!i_reset_n)
                   i_issue_valid && r_outstanding == 4'd0 |->
                   ##1 !o_res_valid ##1 !o_res_valid ##1 !o_res_valid ##1 o_res_valid)
    else $error("Single issue into an empty queue missed the four cycle latency");

endmodule

bind lsu_pipe_top lsu_pipe_props u_props (
  .i_clk          (i_clk),
  .i_reset_n      (i_reset_n),
  .i_issue_valid  (i_issue_valid),
  .i_res_pop      (i_res_pop),
  .o_res_valid    (o_res_valid),
  .o_issue_credit (o_issue_credit)
);

`default_nettype wire

/* tests/tb_lsu_pipe.sv */
// -------------------------------------------------------------------------
// Testbench for the load/store pipeline
// Clock and reset, LCG stimulus, byte model of the data RAM, credit
// tracking, in-order result checks, timeout and the closing summary
// -------------------------------------------------------------------------
`default_nettype none

module tb_lsu_pipe import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  // Init stores, round trip, forwarding pairs, exceptions, back-pressure
  localparam int N_ISSUES       = 160;
  localparam int MAX_GAP        = 4;
  localparam int TIMEOUT_CYCLES = 2 * N_ISSUES * (MAX_GAP + 1) + 200;

  logic              i_clk;
  logic              i_reset_n;
  logic              i_issue_valid;
  logic [TAG_W-1:0]  i_issue_tag;
  logic [INST_W-1:0] i_issue_inst;
  logic [XLEN_W-1:0] i_issue_rs1;
  logic [XLEN_W-1:0] i_issue_rs2;
  logic              o_issue_credit;
  logic              o_res_valid;
  logic [TAG_W-1:0]  o_res_tag;
  logic [XLEN_W-1:0] o_res_data;
  logic              o_res_except_valid;
  except_t           o_res_except_type;
  logic [XLEN_W-1:0] o_res_tval;
  logic              i_res_pop;

  // Reference model and bookkeeping
  logic [7:0]        mem_model [DMEM_DEPTH*DATA_B];
  lsu_result_t       exp_q [$];
  lsu_result_t       head_exp;
  int                credits;
  int                errors;
  int                checks;
  int                cycles;
  int                gap_cnt;
  logic              pop_en;
  logic [TAG_W-1:0]  tag_cnt;
  logic [31:0]       stim_state;
  logic [31:0]       pop_state;

  lsu_pipe_top UUT (.*);

  always #50 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] load_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd2, OPC_LOAD};
  endfunction

  function automatic logic [31:0] store_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  task automatic next_rand(output logic [31:0] r);
    stim_state = lcg_step(stim_state);
    r = stim_state;
  endtask

  // Predicts the result, updates the model and drives one issue cycle
  task automatic issue(input logic [31:0] inst, input logic [63:0] rs1, input logic [63:0] rs2);
    lsu_result_t exp;
    logic [63:0] ofs;
    logic [63:0] addr;
    logic [63:0] val;
    logic [8:0]  idx;
    logic [6:0]  opc;
    logic [2:0]  f3;
    int          nb;
    opc = inst[6:0];
    f3 = inst[14:12];
    nb = 1 << f3[1:0];
    exp = '0;
    exp.tag = tag_cnt;
    if (opc == OPC_LOAD) begin
      ofs = {{52{inst[31]}}, inst[31:20]};
    end else begin
      ofs = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    end
    addr = rs1 + ofs;
    idx = addr[8:0];
    // Trap value is the address unless the encoding is illegal
    exp.tval = addr;
    if (opc != OPC_LOAD && opc != OPC_STORE) begin
      exp.except_valid = 1'b1;
      exp.except_type = EXC_ILLEGAL;
      exp.tval = {32'd0, inst};
    end else if ((addr[2:0] & 3'(nb - 1)) != 3'd0) begin
      exp.except_valid = 1'b1;
      exp.except_type = (opc == OPC_LOAD) ? EXC_LOAD_MISALIGN : EXC_STORE_MISALIGN;
    end else if (opc == OPC_LOAD) begin
      val = '0;
      for (int i = 0; i < nb; i++) begin
        val[i*8 +: 8] = mem_model[idx + 9'(i)];
      end
      // funct3[2] clear means signed
      if (!f3[2]) begin
        for (int i = nb * 8; i < XLEN_W; i++) begin
          val[i] = val[nb*8-1];
        end
      end
      exp.data = val;
    end else begin
      for (int i = 0; i < nb; i++) begin
        mem_model[idx + 9'(i)] = rs2[i*8 +: 8];
      end
    end
    @(negedge i_clk);
    while (credits == 0) begin
      i_issue_valid = 1'b0;
      @(negedge i_clk);
    end
    i_issue_valid = 1'b1;
    i_issue_tag = tag_cnt;
    i_issue_inst = inst;
    i_issue_rs1 = rs1;
    i_issue_rs2 = rs2;
    credits--;
    exp_q.push_back(exp);
    tag_cnt++;
  endtask

  task automatic idle_until_credits(input int n);
    @(negedge i_clk);
    i_issue_valid = 1'b0;
    while (credits < n) begin
      @(negedge i_clk);
    end
  endtask

  task automatic drain_results();
    @(negedge i_clk);
    i_issue_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  // Consumer with random pop gaps
  always @(negedge i_clk) begin
    if (!pop_en) begin
      i_res_pop = 1'b0;
    end else if (gap_cnt == 0) begin
      i_res_pop = 1'b1;
      pop_state = lcg_step(pop_state);
      gap_cnt = int'(pop_state[17:16]);
    end else begin
      i_res_pop = 1'b0;
      gap_cnt--;
    end
  end

  // ---------------------------------------------------------------------------
  // Result checks, credit tracking and timeout
  // ---------------------------------------------------------------------------
  always @(posedge i_clk) begin
    if (i_reset_n) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout after %0d cycles with %0d results still expected",
                 cycles, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
      end else begin
        assert (o_issue_credit == (i_res_pop & o_res_valid)) else begin
          errors++;
          $display("[ERROR] %0t: credit return %0b does not match pop", $time, o_issue_credit);
        end
        if (o_issue_credit) begin
          credits++;
        end
        if (i_res_pop && o_res_valid) begin
          if (exp_q.size() == 0) begin
            errors++;
            $display("A result with tag %0d was popped although none was expected", o_res_tag);
          end else begin
            head_exp = exp_q.pop_front();
            checks++;
            assert (o_res_tag == head_exp.tag && o_res_data == head_exp.data &&
                    o_res_except_valid == head_exp.except_valid &&
                    o_res_except_type == head_exp.except_type &&
                    o_res_tval == head_exp.tval) else begin
              errors++;
              $display("[ERROR] %0t: got tag %0h data %h exc %0b/%0d tval %h", $time,
                       o_res_tag, o_res_data, o_res_except_valid, o_res_except_type,
                       o_res_tval);
              $display("[ERROR] %0t: exp tag %0h data %h exc %0b/%0d tval %h", $time,
                       head_exp.tag, head_exp.data, head_exp.except_valid,
                       head_exp.except_type, head_exp.tval);
            end
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [8:0]  a9;
    logic [2:0]  f3;
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_tag = '0;
    i_issue_inst = '0;
    i_issue_rs1 = '0;
    i_issue_rs2 = '0;
    i_res_pop = 1'b0;
    credits = RESQ_DEPTH;
    errors = 0;
    checks = 0;
    cycles = 0;
    gap_cnt = 0;
    pop_en = 1'b0;
    tag_cnt = '0;
    stim_state = 32'h5238;
    pop_state = 32'h5238;
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    // Fill every doubleword; the first issue also meets the latency property
    pop_en = 1'b1;
    for (int d = 0; d < DMEM_DEPTH; d++) begin
      next_rand(r);
      next_rand(r2);
      issue(store_inst(3'b011, 12'd0), 64'(d * DATA_B), {r, r2});
    end

    // Round trip with an offset of 8 on the base register
    for (int n = 0; n < 50; n++) begin
      next_rand(r);
      next_rand(r2);
      f3 = {r[20], r[1:0]};
      a9 = r[12:4] & ~9'((1 << f3[1:0]) - 1);
      if (n < 20) begin
        issue(store_inst({1'b0, f3[1:0]}, 12'd8), {55'd0, a9} - 64'd8, {r2, r});
      end else begin
        if (f3 == 3'b111) begin
          f3 = 3'b011;
        end
        issue(load_inst(f3, 12'd8), {55'd0, a9} - 64'd8, '0);
      end
    end

    // Store then load of the same doubleword on the next cycle
    for (int n = 0; n < 8; n++) begin
      next_rand(r);
      next_rand(r2);
      a9 = r[12:4] & ~9'((1 << r[1:0]) - 1);
      idle_until_credits(2);
      issue(store_inst({1'b0, r[1:0]}, 12'd0), {55'd0, a9}, {r2, r});
      issue(load_inst(3'b011, 12'd0), {55'd0, a9[8:3], 3'b000}, '0);
    end

    // Misaligned load, misaligned store with read-back, unknown opcode
    issue(load_inst(3'b001, 12'd0), 64'd33, '0);
    issue(load_inst(3'b010, 12'd0), 64'd70, '0);
    issue(store_inst(3'b010, 12'd0), 64'd82, 64'hdead_beef_cafe_f00d);
    issue(store_inst(3'b011, 12'd0), 64'd84, 64'h0123_4567_89ab_cdef);
    issue(load_inst(3'b011, 12'd0), 64'd80, '0);
    issue(32'h0000_0013, 64'd0, '0);

    // Four issues under back-pressure use every credit
    drain_results();
    pop_en = 1'b0;
    for (int n = 0; n < RESQ_DEPTH; n++) begin
      issue(load_inst(3'b011, 12'd0), 64'(n * DATA_B), '0);
    end
    @(negedge i_clk);
    i_issue_valid = 1'b0;
    repeat (10) @(negedge i_clk);
    if (credits != 0 || !o_res_valid) begin
      errors++;
      $display("Back-pressure left %0d credits and result valid at %0b", credits, o_res_valid);
    end
    pop_en = 1'b1;

    drain_results();
    repeat (4) @(negedge i_clk);
    $display("Results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/lsu_pkg.sv
rtl/lsu_stage_if.sv
rtl/lsu_agen.sv
rtl/lsu_data_ram.sv
rtl/lsu_load_align.sv
rtl/lsu_result_queue.sv
rtl/lsu_pipe_top.sv
tests/lsu_pipe_props.sv
tests/tb_lsu_pipe.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the load/store pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_lsu_pipe -o sim_lsu \
  && ./obj_dir/sim_lsu > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "TEST RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
